// File: build.f
logic/rip_pkg.sv
logic/rip_regfile.sv
logic/rip_alu.sv
logic/rip_axi_master.sv
logic/rip_control.sv
logic/rip_core.sv
testbench/rip_axi_mem.sv
testbench/tb_rip_core.sv

// File: testbench/tb_rip_core.sv
`default_nettype none
`timescale 1ns / 1ps

module tb_rip_core;

    localparam logic [31:0] MEM_BASE = 32'h0000_1000;
    localparam int MEM_WORDS = 256;
    localparam logic [31:0] MEM_HEAD = MEM_BASE;
    localparam logic [31:0] DATA_ADDR = 32'h0000_1200;
    localparam logic [31:0] RET_HEAD = 32'h0000_13F0;
    localparam logic [31:0] ECALL = 32'h0000_0073;
    // Executed instructions summed over all tests
    localparam int INSN_TOTAL = 118;
    localparam int WORST_STALL = 8;
    localparam int TIMEOUT_CYCLES = 20 * INSN_TOTAL * WORST_STALL;

    logic clk;
    logic arst_n;
    logic run;
    logic busy;
    logic fault;
    logic [rip_pkg::ADDR_WIDTH-1:0] mem_head;
    logic [rip_pkg::ADDR_WIDTH-1:0] ret_head;
    logic [rip_pkg::ADDR_WIDTH-1:0] awaddr;
    logic [rip_pkg::ADDR_WIDTH-1:0] araddr;
    logic [7:0] awlen;
    logic [7:0] arlen;
    logic [2:0] awsize;
    logic [2:0] arsize;
    logic [1:0] awburst;
    logic [1:0] arburst;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rlast, rvalid, rready;
    logic [rip_pkg::XLEN-1:0] wdata;
    logic [rip_pkg::XLEN-1:0] rdata;
    logic [rip_pkg::STRB_WIDTH-1:0] wstrb;
    logic [1:0] bresp;
    logic [1:0] rresp;
    logic stall_en;
    logic err_en;
    logic [rip_pkg::ADDR_WIDTH-1:0] err_addr;
    int load_idx;
    int cycles;

    rip_core i_rip_core (
        .clk(clk), .arst_n(arst_n), .run(run), .busy(busy), .fault(fault),
        .mem_head(mem_head), .ret_head(ret_head),
        .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
        .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
    );

    rip_axi_mem #(.BASE(MEM_BASE), .WORDS(MEM_WORDS)) i_mem (
        .clk(clk), .arst_n(arst_n), .stall_en(stall_en), .err_en(err_en), .err_addr(err_addr),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the core did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $fatal(1);
    end

    // RV32I encoders
    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, rip_pkg::OP_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rip_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], rip_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rip_pkg::OP_LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rip_pkg::OP_JAL};
    endfunction

    function automatic logic [rip_pkg::XLEN-1:0] read_word(input logic [31:0] addr);
        return i_mem.mem[int'((addr - MEM_BASE) >> 2)];
    endfunction

    task automatic check_word(input string name, input logic [rip_pkg::XLEN-1:0] actual,
                              input logic [rip_pkg::XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // Every write beat is a full and final word
    always @(negedge clk) begin
        if (wvalid === 1'b1) begin
            check_flag("wlast", wlast, 1'b1);
            check_word("wstrb", {28'd0, wstrb}, 32'h0000_000F);
        end
    end

    task automatic start_program();
        load_idx = int'((MEM_HEAD - MEM_BASE) >> 2);
    endtask

    task automatic emit(input logic [31:0] insn);
        i_mem.mem[load_idx] = insn;
        load_idx++;
    endtask

    task automatic run_program();
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b1);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic test_arithmetic();
        logic [rip_pkg::XLEN-1:0] e1, e2, e3, e4, e5, e6, e7, e8, e9;
        start_program();
        emit(u_type(20'h12345, 1));
        emit(i_type(12'h678, 0, 3'b000, 2, rip_pkg::OP_OPIMM));
        emit(r_type(7'h00, 2, 1, 3'b000, 3));
        emit(i_type(12'hFFB, 0, 3'b000, 4, rip_pkg::OP_OPIMM));
        emit(r_type(7'h20, 4, 3, 3'b000, 5));
        emit(r_type(7'h00, 1, 5, 3'b111, 6));
        emit(r_type(7'h00, 2, 6, 3'b110, 7));
        emit(r_type(7'h00, 4, 7, 3'b100, 8));
        emit(r_type(7'h00, 2, 4, 3'b010, 9));
        emit(r_type(7'h00, 9, 8, 3'b000, 10));
        emit(ECALL);
        run_program();
        e1 = {20'h12345, 12'h000};
        e2 = 32'h0000_0678;
        e3 = e1 + e2;
        e4 = 32'hFFFF_FFFB;
        e5 = e3 - e4;
        e6 = e5 & e1;
        e7 = e6 | e2;
        e8 = e7 ^ e4;
        e9 = ($signed(e4) < $signed(e2)) ? 32'd1 : 32'd0;
        check_word("ret_head word", read_word(RET_HEAD), e8 + e9);
        check_flag("fault", fault, 1'b0);
    endtask

    task automatic test_memory();
        logic [rip_pkg::XLEN-1:0] stored;
        start_program();
        emit(u_type(DATA_ADDR[31:12], 1));
        emit(i_type(DATA_ADDR[11:0], 1, 3'b000, 1, rip_pkg::OP_OPIMM));
        emit(u_type(20'hCAFEB, 2));
        emit(i_type(12'h0EE, 2, 3'b000, 2, rip_pkg::OP_OPIMM));
        emit(s_type(12'd8, 2, 1));
        emit(i_type(12'd8, 1, 3'b010, 3, rip_pkg::OP_LOAD));
        emit(i_type(12'h011, 3, 3'b000, 10, rip_pkg::OP_OPIMM));
        emit(ECALL);
        run_program();
        stored = {20'hCAFEB, 12'h000} + 32'h0000_00EE;
        check_word("stored word", read_word(DATA_ADDR + 8), stored);
        check_word("ret_head word", read_word(RET_HEAD), stored + 32'h0000_0011);
        check_flag("fault", fault, 1'b0);
    endtask

    task automatic test_control_flow();
        logic [rip_pkg::XLEN-1:0] sum;
        start_program();
        emit(i_type(12'd10, 0, 3'b000, 1, rip_pkg::OP_OPIMM));
        emit(i_type(12'd0, 0, 3'b000, 10, rip_pkg::OP_OPIMM));
        // Loop body with an ADDI to x0 that must not stick
        emit(r_type(7'h00, 1, 10, 3'b000, 10));
        emit(i_type(12'd7, 0, 3'b000, 0, rip_pkg::OP_OPIMM));
        emit(i_type(12'hFFF, 1, 3'b000, 1, rip_pkg::OP_OPIMM));
        emit(b_type(13'h1FF4, 0, 1, 3'b001));
        emit(j_type(21'd8, 5));
        emit(i_type(12'd100, 10, 3'b000, 10, rip_pkg::OP_OPIMM));
        emit(r_type(7'h00, 0, 10, 3'b000, 10));
        emit(ECALL);
        run_program();
        sum = '0;
        for (int i = 10; i > 0; i--) begin
            sum = sum + i;
        end
        check_word("ret_head word", read_word(RET_HEAD), sum);
        check_flag("fault", fault, 1'b0);
    endtask

    task automatic test_illegal();
        start_program();
        emit(i_type(12'd3, 0, 3'b000, 10, rip_pkg::OP_OPIMM));
        emit(32'h0000_007F);
        run_program();
        check_word("ret_head word", read_word(RET_HEAD), rip_pkg::ILLEGAL_RESULT);
        check_flag("fault", fault, 1'b0);
    endtask

    task automatic test_bus_error();
        logic [rip_pkg::XLEN-1:0] prior;
        start_program();
        emit(i_type(12'd1, 0, 3'b000, 10, rip_pkg::OP_OPIMM));
        emit(i_type(12'd1, 10, 3'b000, 10, rip_pkg::OP_OPIMM));
        emit(i_type(12'd1, 10, 3'b000, 10, rip_pkg::OP_OPIMM));
        emit(ECALL);
        prior = read_word(RET_HEAD);
        @(posedge clk);
        err_en <= 1'b1;
        err_addr <= MEM_HEAD + 8;
        run_program();
        check_flag("fault", fault, 1'b1);
        check_word("ret_head word", read_word(RET_HEAD), prior);
        @(posedge clk);
        err_en <= 1'b0;
        run_program();
        check_flag("fault", fault, 1'b0);
        check_word("ret_head word", read_word(RET_HEAD), 32'd3);
    endtask

    task automatic test_backpressure();
        @(posedge clk);
        stall_en <= 1'b1;
        test_control_flow();
        @(posedge clk);
        stall_en <= 1'b0;
    endtask

    initial begin
        arst_n = 1'b0;
        run = 1'b0;
        mem_head = MEM_HEAD;
        ret_head = RET_HEAD;
        stall_en = 1'b0;
        err_en = 1'b0;
        err_addr = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("fault", fault, 1'b0);
        check_flag("awvalid", awvalid, 1'b0);
        check_flag("wvalid", wvalid, 1'b0);
        check_flag("arvalid", arvalid, 1'b0);
        check_flag("bready", bready, 1'b0);
        check_flag("rready", rready, 1'b0);
        // LEN 0, SIZE 4 bytes, INCR
        check_word("aw len/size/burst", {19'd0, awlen, awsize, awburst},
                   {19'd0, 8'd0, 3'd2, 2'b01});
        check_word("ar len/size/burst", {19'd0, arlen, arsize, arburst},
                   {19'd0, 8'd0, 3'd2, 2'b01});
        test_arithmetic();
        test_memory();
        test_control_flow();
        test_illegal();
        test_bus_error();
        test_backpressure();
        $display("Testbench passed");
        $finish;
    end

endmodule : tb_rip_core

`default_nettype wire

// File: testbench/rip_axi_mem.sv
`default_nettype none
`timescale 1ns / 1ps

module rip_axi_mem #(
    parameter logic [31:0] BASE = 32'h0000_1000,
    parameter int WORDS = 256
) (
    input wire clk,
    input wire arst_n,
    input wire stall_en,
    input wire err_en,
    input wire [rip_pkg::ADDR_WIDTH-1:0] err_addr,
    input wire [rip_pkg::ADDR_WIDTH-1:0] awaddr,
    input wire awvalid,
    output logic awready,
    input wire [rip_pkg::XLEN-1:0] wdata,
    input wire wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input wire bready,
    input wire [rip_pkg::ADDR_WIDTH-1:0] araddr,
    input wire arvalid,
    output logic arready,
    output logic [rip_pkg::XLEN-1:0] rdata,
    output logic [1:0] rresp,
    output logic rlast,
    output logic rvalid,
    input wire rready
);

    logic [rip_pkg::XLEN-1:0] mem [WORDS];
    logic [15:0] lfsr;
    logic [15:0] lfsr_tmp;
    logic [4:0] go;
    logic [rip_pkg::ADDR_WIDTH-1:0] rd_addr_q;
    logic [rip_pkg::ADDR_WIDTH-1:0] wr_addr_q;
    logic [rip_pkg::XLEN-1:0] wr_data_q;
    logic rd_pending;
    logic aw_got;
    logic w_got;

    // Fibonacci taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr - BASE) >> 2);
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 32'h5A5A_0000 ^ (BASE + 4 * i);
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= 16'd90;
            awready <= 1'b0;
            wready <= 1'b0;
            arready <= 1'b0;
            bvalid <= 1'b0;
            bresp <= 2'b00;
            rvalid <= 1'b0;
            rresp <= 2'b00;
            rlast <= 1'b0;
            rdata <= '0;
            rd_pending <= 1'b0;
            aw_got <= 1'b0;
            w_got <= 1'b0;
        end else begin
            // One LFSR step per stall bit
            lfsr_tmp = lfsr;
            for (int k = 0; k < 5; k++) begin
                lfsr_tmp = lfsr_next(lfsr_tmp);
                go[k] = lfsr_tmp[0] || !stall_en;
            end
            lfsr <= lfsr_tmp;
            arready <= go[0];
            awready <= go[1];
            wready <= go[2];

            if (arvalid && arready) begin
                rd_addr_q <= araddr;
                rd_pending <= 1'b1;
            end
            if (rd_pending && !rvalid && go[3]) begin
                rvalid <= 1'b1;
                rlast <= 1'b1;
                rdata <= mem[word_index(rd_addr_q)];
                // SLVERR on the chosen address
                rresp <= (err_en && rd_addr_q == err_addr) ? 2'b10 : rip_pkg::RESP_OKAY;
                rd_pending <= 1'b0;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
                rlast <= 1'b0;
            end

            if (awvalid && awready) begin
                wr_addr_q <= awaddr;
                aw_got <= 1'b1;
            end
            if (wvalid && wready) begin
                wr_data_q <= wdata;
                w_got <= 1'b1;
            end
            if (aw_got && w_got && !bvalid && go[4]) begin
                mem[word_index(wr_addr_q)] <= wr_data_q;
                bvalid <= 1'b1;
                bresp <= rip_pkg::RESP_OKAY;
                aw_got <= 1'b0;
                w_got <= 1'b0;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule : rip_axi_mem

`default_nettype wire

// File: logic/rip_core.sv
`default_nettype none
`timescale 1ns / 1ps

module rip_core (
    input wire clk,
    input wire arst_n,
    input wire run,
    output logic busy,
    output logic fault,
    input wire [rip_pkg::ADDR_WIDTH-1:0] mem_head,
    input wire [rip_pkg::ADDR_WIDTH-1:0] ret_head,
    output logic [rip_pkg::ADDR_WIDTH-1:0] awaddr,
    output logic [7:0] awlen,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic awvalid,
    input wire awready,
    output logic [rip_pkg::XLEN-1:0] wdata,
    output logic [rip_pkg::STRB_WIDTH-1:0] wstrb,
    output logic wlast,
    output logic wvalid,
    input wire wready,
    input wire [1:0] bresp,
    input wire bvalid,
    output logic bready,
    output logic [rip_pkg::ADDR_WIDTH-1:0] araddr,
    output logic [7:0] arlen,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    output logic arvalid,
    input wire arready,
    input wire [rip_pkg::XLEN-1:0] rdata,
    input wire [1:0] rresp,
    input wire rlast,
    input wire rvalid,
    output logic rready
);

    logic [rip_pkg::REG_ADDR_WIDTH-1:0] rs1_addr, rs2_addr, rd_addr;
    logic rf_we;
    logic [rip_pkg::XLEN-1:0] rf_wdata, rs1_data, rs2_data;
    rip_pkg::alu_op_t alu_op;
    logic [rip_pkg::XLEN-1:0] alu_a, alu_b, alu_y;
    logic alu_eq, alu_lt;
    logic rd_req, wr_req, done, err;
    logic [rip_pkg::ADDR_WIDTH-1:0] req_addr;
    logic [rip_pkg::XLEN-1:0] wr_data, rd_data;

    // Single beat, 4 bytes, INCR
    assign awlen = 8'd0;
    assign awsize = 3'b010;
    assign awburst = 2'b01;
    assign arlen = 8'd0;
    assign arsize = 3'b010;
    assign arburst = 2'b01;

    rip_control i_control (
        .clk(clk), .arst_n(arst_n), .run(run),
        .mem_head(mem_head), .ret_head(ret_head),
        .busy(busy), .fault(fault),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .rf_we(rf_we), .rf_wdata(rf_wdata),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_y(alu_y),
        .alu_eq(alu_eq), .alu_lt(alu_lt),
        .rd_req(rd_req), .wr_req(wr_req), .req_addr(req_addr), .wr_data(wr_data),
        .done(done), .err(err), .rd_data(rd_data)
    );

    rip_regfile i_regfile (
        .clk(clk), .arst_n(arst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .we(rf_we), .wdata(rf_wdata),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rip_alu i_alu (
        .op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y), .eq(alu_eq), .lt(alu_lt)
    );

    rip_axi_master i_axi_master (
        .clk(clk), .arst_n(arst_n),
        .rd_req(rd_req), .wr_req(wr_req), .req_addr(req_addr), .wr_data(wr_data),
        .done(done), .err(err), .rd_data(rd_data),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
    );

endmodule : rip_core

`default_nettype wire

// File: logic/rip_control.sv
`default_nettype none
`timescale 1ns / 1ps

module rip_control (
    input wire clk,
    input wire arst_n,
    input wire run,
    input wire [rip_pkg::ADDR_WIDTH-1:0] mem_head,
    input wire [rip_pkg::ADDR_WIDTH-1:0] ret_head,
    output logic busy,
    output logic fault,
    output logic [rip_pkg::REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [rip_pkg::REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [rip_pkg::REG_ADDR_WIDTH-1:0] rd_addr,
    output logic rf_we,
    output logic [rip_pkg::XLEN-1:0] rf_wdata,
    input wire [rip_pkg::XLEN-1:0] rs1_data,
    input wire [rip_pkg::XLEN-1:0] rs2_data,
    output rip_pkg::alu_op_t alu_op,
    output logic [rip_pkg::XLEN-1:0] alu_a,
    output logic [rip_pkg::XLEN-1:0] alu_b,
    input wire [rip_pkg::XLEN-1:0] alu_y,
    input wire alu_eq,
    input wire alu_lt,
    output logic rd_req,
    output logic wr_req,
    output logic [rip_pkg::ADDR_WIDTH-1:0] req_addr,
    output logic [rip_pkg::XLEN-1:0] wr_data,
    input wire done,
    input wire err,
    input wire [rip_pkg::XLEN-1:0] rd_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_FINISH
    } state_t;

    state_t state;
    logic [rip_pkg::ADDR_WIDTH-1:0] pc;
    logic [rip_pkg::ADDR_WIDTH-1:0] pc_plus4;
    logic [rip_pkg::ADDR_WIDTH-1:0] next_pc;
    logic [rip_pkg::XLEN-1:0] ir;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [rip_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic taken;

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign pc_plus4 = pc + 4;

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    // ECALL returns x10
    assign rs1_addr = (opcode == rip_pkg::OP_SYSTEM) ? 5'd10 : ir[19:15];
    assign rs2_addr = ir[24:20];
    assign rd_addr = ir[11:7];

    assign alu_a = rs1_data;
    always_comb begin
        case (opcode)
            rip_pkg::OP_OP, rip_pkg::OP_BRANCH: alu_b = rs2_data;
            rip_pkg::OP_STORE: alu_b = imm_s;
            default: alu_b = imm_i;
        endcase
    end

    always_comb begin
        alu_op = rip_pkg::ALU_ADD;
        if (opcode == rip_pkg::OP_BRANCH) begin
            alu_op = rip_pkg::ALU_SUB;
        end else if (opcode == rip_pkg::OP_OP || opcode == rip_pkg::OP_OPIMM) begin
            case (funct3)
                3'b000: begin
                    alu_op = (opcode == rip_pkg::OP_OP && ir[30]) ? rip_pkg::ALU_SUB
                                                                  : rip_pkg::ALU_ADD;
                end
                3'b010: alu_op = rip_pkg::ALU_SLT;
                3'b100: alu_op = rip_pkg::ALU_XOR;
                3'b110: alu_op = rip_pkg::ALU_OR;
                3'b111: alu_op = rip_pkg::ALU_AND;
                default: alu_op = rip_pkg::ALU_ADD;
            endcase
        end
    end

    // funct3[0] inverts the condition
    assign taken = (funct3[2] ? alu_lt : alu_eq) ^ funct3[0];

    always_comb begin
        if (opcode == rip_pkg::OP_JAL) begin
            next_pc = pc + imm_j;
        end else if (opcode == rip_pkg::OP_BRANCH && taken) begin
            next_pc = pc + imm_b;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        if (state == S_MEM) begin
            rf_wdata = rd_data;
        end else if (opcode == rip_pkg::OP_LUI) begin
            rf_wdata = imm_u;
        end else if (opcode == rip_pkg::OP_JAL) begin
            rf_wdata = pc_plus4;
        end else begin
            rf_wdata = alu_y;
        end
    end

    assign rf_we = (state == S_EXEC && (opcode == rip_pkg::OP_LUI
                    || opcode == rip_pkg::OP_OPIMM || opcode == rip_pkg::OP_OP
                    || opcode == rip_pkg::OP_JAL))
                || (state == S_MEM && done && !err && opcode == rip_pkg::OP_LOAD);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            busy <= 1'b0;
            fault <= 1'b0;
            rd_req <= 1'b0;
            wr_req <= 1'b0;
            pc <= '0;
            ir <= '0;
            req_addr <= '0;
            wr_data <= '0;
        end else begin
            rd_req <= 1'b0;
            wr_req <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (run) begin
                        busy <= 1'b1;
                        fault <= 1'b0;
                        pc <= mem_head;
                        rd_req <= 1'b1;
                        req_addr <= mem_head;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (done) begin
                        ir <= rd_data;
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    case (opcode)
                        rip_pkg::OP_LOAD: begin
                            rd_req <= 1'b1;
                            req_addr <= alu_y;
                            state <= S_MEM;
                        end
                        rip_pkg::OP_STORE: begin
                            wr_req <= 1'b1;
                            req_addr <= alu_y;
                            wr_data <= rs2_data;
                            state <= S_MEM;
                        end
                        rip_pkg::OP_SYSTEM: begin
                            wr_req <= 1'b1;
                            req_addr <= ret_head;
                            wr_data <= rs1_data;
                            state <= S_FINISH;
                        end
                        rip_pkg::OP_LUI, rip_pkg::OP_OPIMM, rip_pkg::OP_OP,
                        rip_pkg::OP_JAL, rip_pkg::OP_BRANCH: begin
                            pc <= next_pc;
                            rd_req <= 1'b1;
                            req_addr <= next_pc;
                            state <= S_FETCH;
                        end
                        default: begin
                            wr_req <= 1'b1;
                            req_addr <= ret_head;
                            wr_data <= rip_pkg::ILLEGAL_RESULT;
                            state <= S_FINISH;
                        end
                    endcase
                end
                S_MEM: begin
                    if (done && !err) begin
                        pc <= pc_plus4;
                        rd_req <= 1'b1;
                        req_addr <= pc_plus4;
                        state <= S_FETCH;
                    end
                end
                S_FINISH: begin
                    if (done) begin
                        busy <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
            // Bus error aborts from any wait state
            if (done && err) begin
                fault <= 1'b1;
                busy <= 1'b0;
                state <= S_IDLE;
            end
        end
    end

    a_one_req: assert property (@(posedge clk) disable iff (!arst_n)
        !(rd_req && wr_req));
    a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        (rd_req || wr_req) |=> !(rd_req || wr_req) until done);

endmodule : rip_control

`default_nettype wire

// File: logic/rip_axi_master.sv
`default_nettype none
`timescale 1ns / 1ps

module rip_axi_master (
    input wire clk,
    input wire arst_n,
    input wire rd_req,
    input wire wr_req,
    input wire [rip_pkg::ADDR_WIDTH-1:0] req_addr,
    input wire [rip_pkg::XLEN-1:0] wr_data,
    output logic done,
    output logic err,
    output logic [rip_pkg::XLEN-1:0] rd_data,
    output logic [rip_pkg::ADDR_WIDTH-1:0] awaddr,
    output logic awvalid,
    input wire awready,
    output logic [rip_pkg::XLEN-1:0] wdata,
    output logic [rip_pkg::STRB_WIDTH-1:0] wstrb,
    output logic wlast,
    output logic wvalid,
    input wire wready,
    input wire [1:0] bresp,
    input wire bvalid,
    output logic bready,
    output logic [rip_pkg::ADDR_WIDTH-1:0] araddr,
    output logic arvalid,
    input wire arready,
    input wire [rip_pkg::XLEN-1:0] rdata,
    input wire [1:0] rresp,
    input wire rlast,
    input wire rvalid,
    output logic rready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE
    } state_t;

    state_t state;
    logic [rip_pkg::ADDR_WIDTH-1:0] addr_q;

    // Full-word single beats only
    assign awaddr = addr_q;
    assign araddr = addr_q;
    assign wstrb = '1;
    assign wlast = 1'b1;
    assign rready = (state == S_READ);
    assign bready = (state == S_WRITE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            arvalid <= 1'b0;
            done <= 1'b0;
            err <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (rd_req) begin
                        arvalid <= 1'b1;
                        state <= S_READ;
                    end else if (wr_req) begin
                        awvalid <= 1'b1;
                        wvalid <= 1'b1;
                        state <= S_WRITE;
                    end
                end
                S_READ: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                    end
                    if (rvalid) begin
                        done <= 1'b1;
                        err <= (rresp != rip_pkg::RESP_OKAY);
                        state <= S_IDLE;
                    end
                end
                S_WRITE: begin
                    // Address and data accepted independently
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                    end
                    if (bvalid) begin
                        done <= 1'b1;
                        err <= (bresp != rip_pkg::RESP_OKAY);
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && (rd_req || wr_req)) begin
            addr_q <= req_addr;
            wdata <= wr_data;
        end
        if (state == S_READ && rvalid) begin
            rd_data <= rdata;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));
    a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr));
    a_w_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wvalid && !wready |=> wvalid && $stable(wdata));
    a_rlast: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid |-> rlast);

endmodule : rip_axi_master

`default_nettype wire

// File: logic/rip_alu.sv
`default_nettype none
`timescale 1ns / 1ps

module rip_alu (
    input wire rip_pkg::alu_op_t op,
    input wire [rip_pkg::XLEN-1:0] a,
    input wire [rip_pkg::XLEN-1:0] b,
    output logic [rip_pkg::XLEN-1:0] y,
    output logic eq,
    output logic lt
);

    // Signed compare shared by SLT and branches
    assign lt = $signed(a) < $signed(b);
    assign eq = (a == b);

    always_comb begin
        case (op)
            rip_pkg::ALU_ADD: begin
                y = a + b;
            end
            rip_pkg::ALU_SUB: begin
                y = a - b;
            end
            rip_pkg::ALU_AND: begin
                y = a & b;
            end
            rip_pkg::ALU_OR: begin
                y = a | b;
            end
            rip_pkg::ALU_XOR: begin
                y = a ^ b;
            end
            rip_pkg::ALU_SLT: begin
                y = {{(rip_pkg::XLEN-1){1'b0}}, lt};
            end
            rip_pkg::ALU_PASSB: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule : rip_alu

`default_nettype wire

// File: logic/rip_regfile.sv
`default_nettype none
`timescale 1ns / 1ps

module rip_regfile (
    input wire clk,
    input wire arst_n,
    input wire [rip_pkg::REG_ADDR_WIDTH-1:0] rs1_addr,
    input wire [rip_pkg::REG_ADDR_WIDTH-1:0] rs2_addr,
    input wire [rip_pkg::REG_ADDR_WIDTH-1:0] rd_addr,
    input wire we,
    input wire [rip_pkg::XLEN-1:0] wdata,
    output logic [rip_pkg::XLEN-1:0] rs1_data,
    output logic [rip_pkg::XLEN-1:0] rs2_data
);

    localparam int NUM_REGS = 2 ** rip_pkg::REG_ADDR_WIDTH;

    logic [rip_pkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= wdata;
        end
    end

    // x0 is reset and never written
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (rs1_addr != '0 || rs1_data == '0) && (rs2_addr != '0 || rs2_data == '0));

endmodule : rip_regfile

`default_nettype wire

// File: logic/rip_pkg.sv
`default_nettype none

package rip_pkg;

    localparam int XLEN = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int STRB_WIDTH = XLEN / 8;

    // RV32I major opcodes
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_OPIMM = 7'b0010011;
    localparam logic [6:0] OP_OP = 7'b0110011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } alu_op_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Reported at ret_head for an unknown opcode
    localparam logic [XLEN-1:0] ILLEGAL_RESULT = '1;

endpackage : rip_pkg

`default_nettype wire
